//--- hdl/phold_pkg.sv
package phold_pkg;

   localparam int LP_ID_W  = 3;
   localparam int TIME_W   = 16;
   localparam int RND_W    = 8;
   localparam int OFFSET_W = 8;
   localparam int MSG_W    = 32;
   localparam int HIST_W   = 32;
   localparam int MIN_GAP  = 10;   // Least time between an event and its child

   typedef logic [LP_ID_W-1:0] lp_id_t;
   typedef logic [TIME_W-1:0]  sim_time_t;
   typedef logic [RND_W-1:0]   rnd_t;
   typedef logic [MSG_W-1:0]   msg_t;          // {zeros, type, target, time}
   typedef logic [HIST_W-1:0]  hist_entry_t;   // {zeros, target, offset, type, time}

   localparam logic EVT_REGULAR = 1'b0;
   localparam logic EVT_CANCEL  = 1'b1;

   typedef enum logic [2:0] {
      IDLE,
      STALL,
      READ_HIST,
      PROC_EVT,
      WRITE_HIST,
      EMIT
   } core_state_t;

   function automatic msg_t make_msg(logic typ, lp_id_t target, sim_time_t t);
      return {{(MSG_W-TIME_W-LP_ID_W-1){1'b0}}, typ, target, t};
   endfunction

   function automatic sim_time_t msg_time(msg_t m);
      return m[TIME_W-1:0];
   endfunction

   function automatic lp_id_t msg_target(msg_t m);
      return m[TIME_W +: LP_ID_W];
   endfunction

   function automatic logic msg_type(msg_t m);
      return m[TIME_W+LP_ID_W];
   endfunction

   function automatic hist_entry_t make_entry(logic typ, lp_id_t target,
                                              logic [OFFSET_W-1:0] offset, sim_time_t t);
      return {{(HIST_W-LP_ID_W-OFFSET_W-1-TIME_W){1'b0}}, target, offset, typ, t};
   endfunction

   function automatic sim_time_t entry_time(hist_entry_t e);
      return e[TIME_W-1:0];
   endfunction

   function automatic logic entry_type(hist_entry_t e);
      return e[TIME_W];
   endfunction

   // Cancels the child that a history entry spawned
   function automatic msg_t spawned_cancel(hist_entry_t e);
      sim_time_t offset;
      offset = sim_time_t'(e[TIME_W+1 +: OFFSET_W]);
      return make_msg(EVT_CANCEL, e[TIME_W+1+OFFSET_W +: LP_ID_W], entry_time(e) + offset);
   endfunction

endpackage

//--- hdl/event_fifo.sv
`timescale 1ns/1ps

module event_fifo #(
   parameter int DEPTH_BITS = 4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   clear,
   input  logic                   wr_en,
   input  phold_pkg::hist_entry_t din,
   input  logic                   rd_en,
   output phold_pkg::hist_entry_t dout,
   output logic                   empty,
   output logic [DEPTH_BITS:0]    count
);

   localparam int DEPTH = 2 ** DEPTH_BITS;

   phold_pkg::hist_entry_t mem [DEPTH];
   logic [DEPTH_BITS-1:0]  wr_ptr;
   logic [DEPTH_BITS-1:0]  rd_ptr;
   logic                   do_wr;
   logic                   do_rd;

   assign do_wr = wr_en && (count != (DEPTH_BITS+1)'(DEPTH));   // Full buffer drops the write
   assign do_rd = rd_en && !empty;
   assign empty = (count == '0);
   assign dout  = mem[rd_ptr];   // Head shows before the read strobe

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1;
            2'b01:   count <= count - 1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

endmodule

//--- hdl/history_filter.sv
`timescale 1ns/1ps

module history_filter (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   start,
   input  logic                   entry_vld,
   input  phold_pkg::hist_entry_t entry,
   input  logic                   cur_type,
   input  phold_pkg::sim_time_t   cur_time,
   input  phold_pkg::sim_time_t   gvt,
   output logic                   keep_entry,
   output logic                   rollback,
   output logic                   matched,
   output logic                   gen_cancel,
   output phold_pkg::msg_t        cancel_msg
);

   phold_pkg::sim_time_t e_time;
   logic                 e_type;
   logic                 expired;
   logic                 twin;
   logic                 straggler;
   logic                 both_regular;

   assign e_time = phold_pkg::entry_time(entry);
   assign e_type = phold_pkg::entry_type(entry);

   // Rules apply in order, an earlier hit masks the later ones
   assign expired = (e_time < gvt);   // Below GVT, can never be rolled back

   // Only the first twin annihilates
   assign twin = !expired && !matched && (e_type != cur_type) && (e_time == cur_time);

   assign both_regular = (cur_type == phold_pkg::EVT_REGULAR) &&
                         (e_type == phold_pkg::EVT_REGULAR);
   assign straggler    = !expired && !twin && both_regular && (e_time > cur_time);

   assign keep_entry = entry_vld && !expired && !twin && !straggler;
   assign rollback   = entry_vld && straggler;

   always_ff @(posedge clk) begin
      if (!rst_n || start) begin
         matched    <= 1'b0;
         gen_cancel <= 1'b0;
      end else if (entry_vld && twin) begin
         matched    <= 1'b1;
         gen_cancel <= (cur_type == phold_pkg::EVT_CANCEL);   // Twin already spawned a child
      end
   end

   // The child of the annihilated twin must be cancelled too
   always_ff @(posedge clk) begin
      if (entry_vld && twin && cur_type == phold_pkg::EVT_CANCEL) begin
         cancel_msg <= phold_pkg::spawned_cancel(entry);
      end
   end

endmodule

//--- hdl/phold_core_ctrl.sv
`timescale 1ns/1ps

module phold_core_ctrl #(
   parameter int HIST_DEPTH_BITS = 4
) (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          event_valid,
   input  phold_pkg::msg_t                               cur_event_msg,
   input  phold_pkg::sim_time_t                          global_time,
   input  phold_pkg::rnd_t                               random_in,
   input  logic                                          stall,
   output logic                                          ready,
   output logic                                          active,
   output logic                                          hist_rq,
   output logic                                          hist_wr_en,
   output logic [phold_pkg::LP_ID_W+HIST_DEPTH_BITS-1:0] hist_addr,
   input  logic [HIST_DEPTH_BITS-1:0]                    hist_size,
   input  logic                                          hist_access_grant,
   output logic                                          entry_vld,
   output logic                                          start,
   output phold_pkg::lp_id_t                             cur_lp,
   output logic                                          cur_type,
   output phold_pkg::sim_time_t                          cur_time,
   output phold_pkg::sim_time_t                          gvt,
   input  logic                                          matched,
   output logic                                          new_entry_wr,
   output phold_pkg::hist_entry_t                        new_entry,
   output phold_pkg::msg_t                               new_msg,
   input  logic                                          wb_empty,
   output logic                                          wb_rd_en,
   output logic                                          emit_start,
   input  logic                                          emit_done
);

   typedef logic [phold_pkg::OFFSET_W-1:0] offset_t;

   phold_pkg::core_state_t     state;
   phold_pkg::core_state_t     state_nxt;
   phold_pkg::rnd_t            rnd;
   logic [HIST_DEPTH_BITS-1:0] slot;
   logic                       granted;
   logic                       last_read;
   offset_t                    new_offset;
   phold_pkg::lp_id_t          new_target;

   assign ready  = (state == phold_pkg::IDLE);
   assign active = !ready;
   assign start  = ready && event_valid;   // Also clears filter flags and both buffers

   always_ff @(posedge clk) begin
      if (start) begin
         cur_lp   <= phold_pkg::msg_target(cur_event_msg);
         cur_type <= phold_pkg::msg_type(cur_event_msg);
         cur_time <= phold_pkg::msg_time(cur_event_msg);
         gvt      <= global_time;
         rnd      <= random_in;
      end
   end

   // Child event, MIN_GAP plus up to 31 ahead, target from the top random bits
   assign new_offset = offset_t'(phold_pkg::MIN_GAP) + offset_t'(rnd[4:0]);
   assign new_target = rnd[phold_pkg::RND_W-1 -: phold_pkg::LP_ID_W];
   assign new_msg    = phold_pkg::make_msg(phold_pkg::EVT_REGULAR, new_target,
                                           cur_time + phold_pkg::sim_time_t'(new_offset));
   assign new_entry  = phold_pkg::make_entry(cur_type, new_target, new_offset, cur_time);
   assign new_entry_wr = (state == phold_pkg::PROC_EVT) && !matched;   // Annihilated events vanish

   // History memory sequencing
   assign hist_rq = ((state == phold_pkg::READ_HIST) && (hist_size != '0)) ||
                    ((state == phold_pkg::WRITE_HIST) && !wb_empty);
   assign hist_wr_en = (state == phold_pkg::WRITE_HIST);
   assign hist_addr  = {cur_lp, slot};   // LP base plus slot
   assign granted    = hist_rq && hist_access_grant;
   assign entry_vld  = granted && (state == phold_pkg::READ_HIST);
   assign wb_rd_en   = granted && (state == phold_pkg::WRITE_HIST);
   assign last_read  = entry_vld && (slot == hist_size - 1);
   assign emit_start = (state == phold_pkg::WRITE_HIST) && wb_empty;

   always_comb begin
      state_nxt = state;
      case (state)
         phold_pkg::IDLE: begin
            if (event_valid) begin
               state_nxt = stall ? phold_pkg::STALL : phold_pkg::READ_HIST;
            end
         end
         phold_pkg::STALL: begin
            if (!stall) begin
               state_nxt = phold_pkg::READ_HIST;
            end
         end
         phold_pkg::READ_HIST: begin
            if (hist_size == '0 || last_read) begin   // Empty history skips the reads
               state_nxt = phold_pkg::PROC_EVT;
            end
         end
         phold_pkg::PROC_EVT: state_nxt = phold_pkg::WRITE_HIST;
         phold_pkg::WRITE_HIST: begin
            if (wb_empty) begin
               state_nxt = phold_pkg::EMIT;
            end
         end
         phold_pkg::EMIT: begin
            if (emit_done) begin
               state_nxt = phold_pkg::IDLE;
            end
         end
         default: state_nxt = phold_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= phold_pkg::IDLE;
         slot  <= '0;
      end else begin
         state <= state_nxt;
         if (start || last_read) begin
            slot <= '0;   // Writes restart at slot 0
         end else if (granted) begin
            slot <= slot + 1;
         end
      end
   end

endmodule

//--- hdl/event_emitter.sv
`timescale 1ns/1ps

module event_emitter (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   emit_start,
   output logic                   emit_done,
   input  logic                   matched,
   input  logic                   gen_cancel,
   input  phold_pkg::msg_t        cancel_msg,
   input  logic                   cur_type,
   input  phold_pkg::lp_id_t      cur_lp,
   input  phold_pkg::msg_t        new_msg,
   input  phold_pkg::hist_entry_t rbk_entry,
   input  logic                   rbk_empty,
   output logic                   rbk_rd_en,
   input  logic                   ack,
   output logic                   new_event_ready,
   output phold_pkg::msg_t        out_event_msg
);

   phold_pkg::msg_t first_msg;
   phold_pkg::msg_t null_msg;
   phold_pkg::msg_t rbk_cancel;
   phold_pkg::msg_t rbk_regular;
   logic            reissue;   // Head entry still owes its re-issued event
   logic            take;

   assign null_msg    = phold_pkg::make_msg(phold_pkg::EVT_CANCEL, '0, '0);
   assign rbk_cancel  = phold_pkg::spawned_cancel(rbk_entry);
   assign rbk_regular = phold_pkg::make_msg(phold_pkg::EVT_REGULAR, cur_lp,
                                            phold_pkg::entry_time(rbk_entry));

   always_comb begin
      if (matched && gen_cancel) begin
         first_msg = cancel_msg;
      end else if (matched || cur_type == phold_pkg::EVT_CANCEL) begin
         first_msg = null_msg;   // Nothing new to spawn
      end else begin
         first_msg = new_msg;
      end
   end

   assign take      = new_event_ready && ack;
   assign emit_done = take && !reissue && rbk_empty;
   assign rbk_rd_en = take && reissue;   // Pop once both messages are out

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         new_event_ready <= 1'b0;
         reissue         <= 1'b0;
      end else if (emit_start) begin
         new_event_ready <= 1'b1;
         reissue         <= 1'b0;
      end else if (take) begin
         new_event_ready <= !emit_done;
         reissue         <= !reissue && !rbk_empty;
      end
   end

   // Message holds until ack
   always_ff @(posedge clk) begin
      if (emit_start) begin
         out_event_msg <= first_msg;
      end else if (take && !rbk_empty) begin
         out_event_msg <= reissue ? rbk_regular : rbk_cancel;
      end
   end

endmodule

//--- hdl/phold_core.sv
`timescale 1ns/1ps

module phold_core #(
   parameter int HIST_DEPTH_BITS = 4
) (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          event_valid,
   input  phold_pkg::msg_t                               cur_event_msg,
   input  phold_pkg::sim_time_t                          global_time,
   input  phold_pkg::rnd_t                               random_in,
   input  logic                                          stall,
   output logic                                          ready,
   output logic                                          active,
   output logic                                          new_event_ready,
   output phold_pkg::msg_t                               out_event_msg,
   input  logic                                          ack,
   output logic                                          hist_rq,
   output logic                                          hist_wr_en,
   output logic [phold_pkg::LP_ID_W+HIST_DEPTH_BITS-1:0] hist_addr,
   output phold_pkg::hist_entry_t                        hist_data_wr,
   input  phold_pkg::hist_entry_t                        hist_data_rd,
   input  logic                                          hist_access_grant,
   input  logic [HIST_DEPTH_BITS-1:0]                    hist_size
);

   logic                   entry_vld;
   logic                   start;
   phold_pkg::lp_id_t      cur_lp;
   logic                   cur_type;
   phold_pkg::sim_time_t   cur_time;
   phold_pkg::sim_time_t   gvt;
   logic                   keep_entry;
   logic                   rollback;
   logic                   matched;
   logic                   gen_cancel;
   phold_pkg::msg_t        cancel_msg;
   logic                   new_entry_wr;
   phold_pkg::hist_entry_t new_entry;
   phold_pkg::msg_t        new_msg;
   logic                   wb_wr_en;
   phold_pkg::hist_entry_t wb_din;
   logic                   wb_empty;
   logic                   wb_rd_en;
   phold_pkg::hist_entry_t rbk_entry;
   logic                   rbk_empty;
   logic                   rbk_rd_en;
   logic                   emit_start;
   logic                   emit_done;

   // Survivors first, new event record last
   assign wb_wr_en = keep_entry || new_entry_wr;
   assign wb_din   = new_entry_wr ? new_entry : hist_data_rd;

   phold_core_ctrl #(
      .HIST_DEPTH_BITS (HIST_DEPTH_BITS)
   ) ctrl (
      .clk, .rst_n, .event_valid, .cur_event_msg, .global_time, .random_in, .stall,
      .ready, .active, .hist_rq, .hist_wr_en, .hist_addr, .hist_size, .hist_access_grant,
      .entry_vld, .start, .cur_lp, .cur_type, .cur_time, .gvt, .matched,
      .new_entry_wr, .new_entry, .new_msg, .wb_empty, .wb_rd_en, .emit_start, .emit_done
   );

   history_filter filter (
      .clk, .rst_n, .start, .entry_vld, .entry (hist_data_rd), .cur_type, .cur_time, .gvt,
      .keep_entry, .rollback, .matched, .gen_cancel, .cancel_msg
   );

   event_emitter emitter (
      .clk, .rst_n, .emit_start, .emit_done, .matched, .gen_cancel, .cancel_msg,
      .cur_type, .cur_lp, .new_msg, .rbk_entry, .rbk_empty, .rbk_rd_en,
      .ack, .new_event_ready, .out_event_msg
   );

   event_fifo #(
      .DEPTH_BITS (HIST_DEPTH_BITS)
   ) wb_buffer (
      .clk, .rst_n, .clear (start), .wr_en (wb_wr_en), .din (wb_din),
      .rd_en (wb_rd_en), .dout (hist_data_wr), .empty (wb_empty), .count ()
   );

   // Straggler victims waiting for cancel and re-issue
   event_fifo #(
      .DEPTH_BITS (HIST_DEPTH_BITS)
   ) rbk_buffer (
      .clk, .rst_n, .clear (start), .wr_en (rollback), .din (hist_data_rd),
      .rd_en (rbk_rd_en), .dout (rbk_entry), .empty (rbk_empty), .count ()
   );

endmodule

//--- verification/phold_core_tb.sv
`timescale 1ns/1ps

module phold_core_tb;

   localparam int   HIST_DEPTH_BITS = 4;
   localparam int   ADDR_W          = phold_pkg::LP_ID_W + HIST_DEPTH_BITS;
   localparam int   MEM_WORDS       = 2 ** ADDR_W;
   localparam int   WAIT_LIMIT      = 400;   // Cycles any single wait may take
   localparam logic REGULAR         = 1'b0;
   localparam logic CANCEL          = 1'b1;

   logic                       clk;
   logic                       rst_n;
   logic                       event_valid;
   phold_pkg::msg_t            cur_event_msg;
   phold_pkg::sim_time_t       global_time;
   phold_pkg::rnd_t            random_in;
   logic                       stall;
   logic                       ready;
   logic                       active;
   logic                       new_event_ready;
   phold_pkg::msg_t            out_event_msg;
   logic                       ack;
   logic                       hist_rq;
   logic                       hist_wr_en;
   logic [ADDR_W-1:0]          hist_addr;
   phold_pkg::hist_entry_t     hist_data_wr;
   phold_pkg::hist_entry_t     hist_data_rd;
   logic                       hist_access_grant = 1'b0;
   logic [HIST_DEPTH_BITS-1:0] hist_size;

   integer                     seed;
   phold_pkg::hist_entry_t     hist_mem [MEM_WORDS];
   logic                       grant_pat [256];   // Precomputed grant gaps
   logic [7:0]                 grant_idx = '0;
   phold_pkg::hist_entry_t     wr_data_log [$];
   logic [ADDR_W-1:0]          wr_addr_log [$];
   logic [ADDR_W-1:0]          rd_addr_log [$];

   phold_core #(
      .HIST_DEPTH_BITS (HIST_DEPTH_BITS)
   ) dut (
      .clk, .rst_n, .event_valid, .cur_event_msg, .global_time, .random_in, .stall,
      .ready, .active, .new_event_ready, .out_event_msg, .ack,
      .hist_rq, .hist_wr_en, .hist_addr, .hist_data_wr, .hist_data_rd,
      .hist_access_grant, .hist_size
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      grant_idx         <= grant_idx + 8'd1;
      hist_access_grant <= grant_pat[grant_idx];
   end

   // History memory with combinational reads
   assign hist_data_rd = hist_mem[hist_addr];

   // A transfer seen at the falling edge completes on the next rising edge
   always @(negedge clk) begin
      if (rst_n && hist_rq && hist_access_grant) begin
         if (hist_wr_en) begin
            wr_addr_log.push_back(hist_addr);
            wr_data_log.push_back(hist_data_wr);
         end else begin
            rd_addr_log.push_back(hist_addr);
         end
      end
   end

   task automatic fail_stop(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_msg(input string name, input phold_pkg::msg_t exp,
                            input phold_pkg::msg_t act);
      if (act !== exp) begin
         fail_stop($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_entry(input string name, input phold_pkg::hist_entry_t exp,
                              input phold_pkg::hist_entry_t act);
      if (act !== exp) begin
         fail_stop($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         fail_stop($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
      end
   endtask

   function automatic phold_pkg::msg_t pack_msg(input logic typ,
         input phold_pkg::lp_id_t target, input phold_pkg::sim_time_t t);
      phold_pkg::msg_t m;
      m        = '0;
      m[15:0]  = t;
      m[18:16] = target;
      m[19]    = typ;
      return m;
   endfunction

   function automatic phold_pkg::hist_entry_t pack_entry(input logic typ,
         input phold_pkg::lp_id_t target, input logic [7:0] offset,
         input phold_pkg::sim_time_t t);
      phold_pkg::hist_entry_t e;
      e        = '0;
      e[15:0]  = t;
      e[16]    = typ;
      e[24:17] = offset;
      e[27:25] = target;
      return e;
   endfunction

   // Expected output messages and rewritten history for one event
   function automatic void expect_event(
         input  phold_pkg::msg_t        ev,
         input  phold_pkg::sim_time_t   gvt,
         input  phold_pkg::rnd_t        rnd,
         input  phold_pkg::hist_entry_t hist [$],
         output phold_pkg::msg_t        msgs [$],
         output phold_pkg::hist_entry_t kept [$]);
      logic                   ev_type;
      phold_pkg::sim_time_t   ev_time;
      phold_pkg::lp_id_t      ev_lp;
      logic                   twin_seen;
      phold_pkg::msg_t        twin_cancel;
      phold_pkg::hist_entry_t victims [$];
      phold_pkg::sim_time_t   e_time;
      logic                   e_type;
      logic [7:0]             child_off;
      phold_pkg::lp_id_t      child_lp;

      msgs        = {};
      kept        = {};
      ev_time     = ev[15:0];
      ev_lp       = ev[18:16];
      ev_type     = ev[19];
      twin_seen   = 1'b0;
      twin_cancel = '0;
      foreach (hist[i]) begin
         e_time = hist[i][15:0];
         e_type = hist[i][16];
         if (e_time < gvt) begin
            continue;   // Committed for good
         end
         if (!twin_seen && e_type != ev_type && e_time == ev_time) begin
            twin_seen   = 1'b1;
            twin_cancel = pack_msg(CANCEL, hist[i][27:25],
                                   e_time + phold_pkg::sim_time_t'(hist[i][24:17]));
            continue;
         end
         if (ev_type == REGULAR && e_type == REGULAR && e_time > ev_time) begin
            victims.push_back(hist[i]);
         end else begin
            kept.push_back(hist[i]);
         end
      end
      child_off = 8'(phold_pkg::MIN_GAP) + {3'b000, rnd[4:0]};
      child_lp  = rnd[7:5];
      if (!twin_seen) begin
         kept.push_back(pack_entry(ev_type, child_lp, child_off, ev_time));
      end
      if (twin_seen && ev_type == CANCEL) begin
         msgs.push_back(twin_cancel);
      end else if (twin_seen || ev_type == CANCEL) begin
         msgs.push_back(pack_msg(CANCEL, 3'd0, 16'd0));   // Null message
      end else begin
         msgs.push_back(pack_msg(REGULAR, child_lp, ev_time + phold_pkg::sim_time_t'(child_off)));
      end
      foreach (victims[i]) begin
         msgs.push_back(pack_msg(CANCEL, victims[i][27:25],
                        victims[i][15:0] + phold_pkg::sim_time_t'(victims[i][24:17])));
         msgs.push_back(pack_msg(REGULAR, ev_lp, victims[i][15:0]));
      end
   endfunction

   task automatic run_event(input string name, input phold_pkg::msg_t ev,
                            input phold_pkg::sim_time_t gvt,
                            input phold_pkg::hist_entry_t hist [$],
                            input int stall_cycles, input int ack_max);
      phold_pkg::rnd_t        rnd;
      phold_pkg::lp_id_t      lp;
      phold_pkg::msg_t        exp_msgs [$];
      phold_pkg::hist_entry_t exp_hist [$];
      int                     wr_base;
      int                     rd_base;
      int                     n_msgs;
      int                     delay;
      int                     cycles;

      rnd = phold_pkg::rnd_t'($random(seed));
      lp  = ev[18:16];
      expect_event(ev, gvt, rnd, hist, exp_msgs, exp_hist);
      foreach (hist[i]) begin
         hist_mem[{lp, HIST_DEPTH_BITS'(i)}] = hist[i];
      end
      wr_base = wr_data_log.size();
      rd_base = rd_addr_log.size();

      @(posedge clk);
      event_valid   <= 1'b1;
      cur_event_msg <= ev;
      global_time   <= gvt;
      random_in     <= rnd;
      stall         <= (stall_cycles > 0);
      hist_size     <= HIST_DEPTH_BITS'(hist.size());
      @(posedge clk);   // Accepted on this edge
      event_valid <= 1'b0;
      @(negedge clk);
      check_bit({name, " active after accept"}, 1'b1, active);
      check_bit({name, " ready after accept"}, 1'b0, ready);

      for (int i = 0; i < stall_cycles; i++) begin
         check_bit({name, " hist_rq in stall"}, 1'b0, hist_rq);
         check_bit({name, " active in stall"}, 1'b1, active);
         @(negedge clk);
      end
      @(posedge clk);
      stall <= 1'b0;
      @(negedge clk);

      cycles = 0;
      while (!new_event_ready) begin
         check_bit({name, " ready while busy"}, 1'b0, ready);
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            fail_stop({name, ": timed out waiting for the first output message"});
         end
      end

      n_msgs = 0;
      while (new_event_ready) begin
         if (n_msgs >= exp_msgs.size()) begin
            fail_stop({name, ": the core sent more output messages than expected"});
         end
         check_msg($sformatf("%s message %0d", name, n_msgs), exp_msgs[n_msgs], out_event_msg);
         check_bit({name, " ready before last ack"}, 1'b0, ready);
         delay = $unsigned($random(seed)) % (ack_max + 1);
         for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            check_bit({name, " new_event_ready hold"}, 1'b1, new_event_ready);
            check_msg({name, " message hold"}, exp_msgs[n_msgs], out_event_msg);
         end
         @(posedge clk);
         ack <= 1'b1;
         @(posedge clk);
         ack <= 1'b0;
         @(negedge clk);
         n_msgs++;
      end
      if (n_msgs != exp_msgs.size()) begin
         fail_stop($sformatf("%s: the core sent %0d messages instead of %0d",
                             name, n_msgs, exp_msgs.size()));
      end
      check_bit({name, " ready after last ack"}, 1'b1, ready);
      check_bit({name, " active after last ack"}, 1'b0, active);

      if (rd_addr_log.size() - rd_base != hist.size()) begin
         fail_stop({name, ": the core did not read each history slot exactly once"});
      end
      foreach (hist[i]) begin
         if (rd_addr_log[rd_base + i] != {lp, HIST_DEPTH_BITS'(i)}) begin
            fail_stop({name, ": a history read went to the wrong address"});
         end
      end
      if (wr_data_log.size() - wr_base != exp_hist.size()) begin
         fail_stop($sformatf("%s: %0d history writes seen, %0d expected",
                             name, wr_data_log.size() - wr_base, exp_hist.size()));
      end
      foreach (exp_hist[i]) begin
         check_entry($sformatf("%s history slot %0d", name, i), exp_hist[i],
                     wr_data_log[wr_base + i]);
         if (wr_addr_log[wr_base + i] != {lp, HIST_DEPTH_BITS'(i)}) begin
            fail_stop({name, ": a history write went to the wrong address"});
         end
         hist_mem[wr_addr_log[wr_base + i]] = wr_data_log[wr_base + i];   // Commit
      end
   endtask

   initial begin
      phold_pkg::hist_entry_t h [$];

      seed          = 32'h42fe_87db;
      rst_n         <= 1'b0;
      event_valid   <= 1'b0;
      cur_event_msg <= '0;
      global_time   <= '0;
      random_in     <= '0;
      stall         <= 1'b0;
      ack           <= 1'b0;
      hist_size     <= '0;
      for (int i = 0; i < 256; i++) begin
         grant_pat[8'(i)] = ($random(seed) % 4) != 0;   // About one cycle in four without grant
      end
      for (int a = 0; a < MEM_WORDS; a++) begin
         hist_mem[ADDR_W'(a)] = phold_pkg::hist_entry_t'(32'h5a3c_0000 ^ (a * 32'h0001_0193));
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_bit("reset ready", 1'b1, ready);
      check_bit("reset active", 1'b0, active);
      check_bit("reset new_event_ready", 1'b0, new_event_ready);
      check_bit("reset hist_rq", 1'b0, hist_rq);

      h.delete();
      run_event("empty history", pack_msg(REGULAR, 3'd2, 16'd100), 16'd50, h, 0, 2);

      // Expired, earlier and later entries around a regular event at 100
      h.delete();
      h.push_back(pack_entry(REGULAR, 3'd1, 8'd15, 16'd20));
      h.push_back(pack_entry(REGULAR, 3'd3, 8'd12, 16'd70));
      h.push_back(pack_entry(REGULAR, 3'd6, 8'd20, 16'd130));
      h.push_back(pack_entry(CANCEL, 3'd2, 8'd11, 16'd140));
      h.push_back(pack_entry(REGULAR, 3'd0, 8'd30, 16'd160));
      h.push_back(pack_entry(REGULAR, 3'd4, 8'd11, 16'd90));
      run_event("straggler rollback", pack_msg(REGULAR, 3'd5, 16'd100), 16'd40, h, 0, 2);

      h.delete();
      h.push_back(pack_entry(REGULAR, 3'd2, 8'd14, 16'd180));
      h.push_back(pack_entry(REGULAR, 3'd6, 8'd12, 16'd200));
      h.push_back(pack_entry(REGULAR, 3'd7, 8'd25, 16'd220));
      run_event("cancel with twin", pack_msg(CANCEL, 3'd1, 16'd200), 16'd100, h, 0, 2);

      // Anti-message arrived before its regular event
      h.delete();
      h.push_back(pack_entry(REGULAR, 3'd1, 8'd19, 16'd280));
      h.push_back(pack_entry(CANCEL, 3'd5, 8'd17, 16'd300));
      run_event("early anti-message", pack_msg(REGULAR, 3'd3, 16'd300), 16'd250, h, 0, 1);

      h.delete();
      h.push_back(pack_entry(REGULAR, 3'd6, 8'd13, 16'd390));
      h.push_back(pack_entry(CANCEL, 3'd2, 8'd10, 16'd400));
      run_event("cancel without twin", pack_msg(CANCEL, 3'd4, 16'd400), 16'd350, h, 0, 1);

      h.delete();
      h.push_back(pack_entry(REGULAR, 3'd3, 8'd16, 16'd440));
      h.push_back(pack_entry(REGULAR, 3'd2, 8'd21, 16'd470));
      h.push_back(pack_entry(REGULAR, 3'd7, 8'd10, 16'd520));
      h.push_back(pack_entry(CANCEL, 3'd1, 8'd18, 16'd530));
      h.push_back(pack_entry(REGULAR, 3'd5, 8'd27, 16'd510));
      run_event("stall and slow ack", pack_msg(REGULAR, 3'd6, 16'd500), 16'd450, h,
                3 + ($unsigned($random(seed)) % 6), 6);

      $display("TEST OK");
      $finish;
   end

endmodule

//--- vlog.f
hdl/phold_pkg.sv
hdl/event_fifo.sv
hdl/history_filter.sv
hdl/phold_core_ctrl.sv
hdl/event_emitter.sv
hdl/phold_core.sv
verification/phold_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the PHOLD core testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
   --top-module phold_core_tb -Mdir obj_dir -f vlog.f

# The simulator exit code is ignored here, the log decides
./obj_dir/Vphold_core_tb | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation finished without failures"
